// ==== source/bist_pkg.sv ====
// sizes, state and phase encodings, march backgrounds
// and the bus structs shared by the BIST stages
`default_nettype none

package bist_pkg;

    // array geometry and operand widths
    localparam int systolic_size    = 8;
    localparam int weight_width     = 8;
    localparam int activation_width = 8;
    localparam int psum_width       = weight_width + activation_width + 3;  // 19 bits
    localparam int addr_width       = 3;

    localparam int sa_pattern_depth    = 12;  // stuck-at patterns in eNVM
    localparam int mbist_pattern_depth = 8;   // march backgrounds
    localparam int pattern_idx_width   = 4;

    localparam logic [2:0] shift_last = 3'd7;  // 8 shift cycles per pattern

    // terminal counter values
    localparam logic [addr_width-1:0] addr_last =
        addr_width'(systolic_size - 1);
    localparam logic [pattern_idx_width-1:0] mbist_last_idx =
        pattern_idx_width'(mbist_pattern_depth - 1);
    localparam logic [pattern_idx_width-1:0] sa_last_idx =
        pattern_idx_width'(sa_pattern_depth - 1);

    localparam logic [psum_width-1:0] mbist_background [mbist_pattern_depth] = '{
        19'h00000,  // all zeros
        19'h7ffff,  // all ones
        19'h55555,  // 1010... from msb
        19'h2aaaa,  // 0101... from msb
        19'h003ff,  // lower half ones
        19'h7fc00,  // upper half ones
        19'h08421,  // walking one per nibble
        19'h77bde   // walking zero per nibble
    };

    typedef enum logic [4:0] {
        idle,
        mbist_start,
        mbist_write,     // write-only cycle at address 0
        mbist_check,     // write a+1, read a
        mbist_drain,     // last read, then its compare
        lbist_start,
        sa_shift,
        sa_capture,
        sa_final_shift,
        test_complete,
        fail
    } bist_state_e;

    // cycle type seen by execute and result stages
    typedef enum logic [2:0] {
        none,
        mem_write,
        mem_write_read,
        mem_read,
        scan_in,
        capture,
        scan_out
    } bist_phase_e;

    typedef struct packed {
        bist_phase_e                  phase;
        logic [pattern_idx_width-1:0] pattern_idx;
        logic [addr_width-1:0]        mem_addr;    // write address in memory phases
        logic [2:0]                   shift_cnt;
        logic                         compare_en;
        logic                         run_start;   // first cycle of a run
    } bist_ctrl_t;

    typedef logic [systolic_size-1:0][psum_width-1:0] psum_row_t;

    typedef struct packed {
        logic [systolic_size-1:0][weight_width-1:0]     weight;
        logic [systolic_size-1:0][activation_width-1:0] activation;
        psum_row_t                                      psum;
    } test_vec_t;

    // accumulator memory port
    typedef struct packed {
        logic                  wr_en;
        logic [addr_width-1:0] wr_addr;
        psum_row_t             wr_data;
        logic [addr_width-1:0] rd_addr;
    } acc_port_t;

    // one pattern entry as stored in eNVM
    typedef struct packed {
        logic [weight_width-1:0]     weight;
        logic [activation_width-1:0] activation;
        logic [psum_width-1:0]       partial_sum;
        logic [psum_width-1:0]       answer;
    } envm_word_t;

endpackage

`default_nettype wire

// ==== source/bist_sequencer.sv ====
// decode stage of the BIST controller
// state machine with pattern, address and shift counters
`timescale 1ns/1ps
`default_nettype none

module bist_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic                 test_mode,
    input  logic                 bist_mode,   // 0 memory, 1 logic
    input  logic                 mismatch,    // memory read error from checker
    output bist_pkg::bist_ctrl_t ctrl,
    output logic                 scan_en,
    output logic                 test_done,
    output logic                 mbist_fail
);

    bist_pkg::bist_state_e state;
    bist_pkg::bist_state_e next_state;

    logic [bist_pkg::pattern_idx_width-1:0] pattern_cnt;
    logic [bist_pkg::addr_width-1:0]        addr_cnt;
    logic [2:0]                             shift_cnt;
    logic                                   run_req;
    logic                                   mem_last;

    assign run_req  = start && test_mode;
    // last address of the last background
    assign mem_last = (addr_cnt == bist_pkg::addr_last) &&
                      (pattern_cnt == bist_pkg::mbist_last_idx);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bist_pkg::idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            bist_pkg::idle: begin
                if (run_req) begin
                    next_state = bist_mode ? bist_pkg::lbist_start : bist_pkg::mbist_start;
                end
            end
            bist_pkg::mbist_start: next_state = bist_pkg::mbist_write;
            bist_pkg::mbist_write: next_state = bist_pkg::mbist_check;
            bist_pkg::mbist_check: begin
                if (mismatch) begin
                    next_state = bist_pkg::fail;
                end else if (mem_last) begin
                    next_state = bist_pkg::mbist_drain;
                end
            end
            bist_pkg::mbist_drain: begin
                if (mismatch) begin
                    next_state = bist_pkg::fail;
                end else if (shift_cnt == 3'd1) begin  // drain read, then its compare
                    next_state = bist_pkg::test_complete;
                end
            end
            bist_pkg::lbist_start: next_state = bist_pkg::sa_shift;
            bist_pkg::sa_shift: begin
                if (shift_cnt == bist_pkg::shift_last) begin
                    next_state = bist_pkg::sa_capture;
                end
            end
            bist_pkg::sa_capture: begin
                if (pattern_cnt == bist_pkg::sa_last_idx) begin
                    next_state = bist_pkg::sa_final_shift;
                end else begin
                    next_state = bist_pkg::sa_shift;
                end
            end
            bist_pkg::sa_final_shift: begin
                if (shift_cnt == bist_pkg::shift_last) begin
                    next_state = bist_pkg::test_complete;
                end
            end
            bist_pkg::test_complete,
            bist_pkg::fail: begin
                if (!start) begin
                    next_state = bist_pkg::idle;  // results held until start drops
                end
            end
            default: next_state = bist_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pattern_cnt <= '0;
            addr_cnt    <= '0;
            shift_cnt   <= '0;
        end else begin
            case (state)
                bist_pkg::idle,
                bist_pkg::mbist_start,
                bist_pkg::lbist_start: begin
                    pattern_cnt <= '0;
                    addr_cnt    <= '0;
                    shift_cnt   <= '0;
                end
                bist_pkg::mbist_write: addr_cnt <= addr_cnt + 1'b1;
                bist_pkg::mbist_check: begin
                    addr_cnt <= addr_cnt + 1'b1;  // wraps after 7
                    if (addr_cnt == bist_pkg::addr_last && !mem_last) begin
                        pattern_cnt <= pattern_cnt + 1'b1;  // next background
                    end
                end
                bist_pkg::mbist_drain,
                bist_pkg::sa_shift,
                bist_pkg::sa_final_shift: shift_cnt <= shift_cnt + 1'b1;
                bist_pkg::sa_capture: begin
                    shift_cnt <= '0;
                    if (pattern_cnt != bist_pkg::sa_last_idx) begin
                        pattern_cnt <= pattern_cnt + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // state to phase decode for execute and result stages
    always_comb begin
        ctrl.phase       = bist_pkg::none;
        ctrl.pattern_idx = pattern_cnt;
        ctrl.mem_addr    = addr_cnt;
        ctrl.shift_cnt   = shift_cnt;
        ctrl.compare_en  = 1'b0;
        ctrl.run_start   = (state == bist_pkg::mbist_start) || (state == bist_pkg::lbist_start);
        case (state)
            bist_pkg::mbist_write: ctrl.phase = bist_pkg::mem_write;
            bist_pkg::mbist_check: begin
                ctrl.phase      = bist_pkg::mem_write_read;
                ctrl.compare_en = 1'b1;
            end
            bist_pkg::mbist_drain: begin
                if (shift_cnt == 3'd0) begin
                    ctrl.phase      = bist_pkg::mem_read;
                    ctrl.compare_en = 1'b1;
                end
            end
            bist_pkg::sa_shift: begin
                ctrl.phase      = bist_pkg::scan_in;
                ctrl.compare_en = (pattern_cnt != '0);  // previous response shifting out
            end
            bist_pkg::sa_capture: ctrl.phase = bist_pkg::capture;
            bist_pkg::sa_final_shift: begin
                ctrl.phase      = bist_pkg::scan_out;
                ctrl.compare_en = 1'b1;
            end
            default: ;
        endcase
    end

    assign scan_en    = (state == bist_pkg::sa_shift) || (state == bist_pkg::sa_final_shift);
    assign test_done  = (state == bist_pkg::test_complete) || (state == bist_pkg::fail);
    assign mbist_fail = (state == bist_pkg::fail);

endmodule

`default_nettype wire

// ==== source/pattern_driver.sv ====
// execute stage of the BIST controller
// broadcast scan vectors and accumulator march port
`timescale 1ns/1ps
`default_nettype none

module pattern_driver (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bist_pkg::bist_ctrl_t ctrl,
    input  bist_pkg::envm_word_t envm,
    output bist_pkg::test_vec_t  test_vec,
    output bist_pkg::acc_port_t  acc
);

    localparam int bg_sel_width = $clog2(bist_pkg::mbist_pattern_depth);

    logic [bist_pkg::psum_width-1:0] psum_dly;  // partial sum lags operands by a cycle
    logic [bist_pkg::psum_width-1:0] bg_word;
    logic [bg_sel_width-1:0]         bg_sel;
    logic                            mem_wr;

    // psum register sits one stage deeper in the PE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_dly <= '0;
        end else begin
            psum_dly <= envm.partial_sum;
        end
    end

    always_comb begin
        test_vec = '0;  // idle lanes stay quiet
        if (ctrl.phase == bist_pkg::scan_in) begin
            test_vec.weight     = {bist_pkg::systolic_size{envm.weight}};
            test_vec.activation = {bist_pkg::systolic_size{envm.activation}};
            test_vec.psum       = {bist_pkg::systolic_size{psum_dly}};
        end
    end

    // background word for the current march pass
    assign bg_sel  = ctrl.pattern_idx[bg_sel_width-1:0];
    assign bg_word = bist_pkg::mbist_background[bg_sel];

    assign mem_wr = (ctrl.phase == bist_pkg::mem_write) ||
                    (ctrl.phase == bist_pkg::mem_write_read);

    always_comb begin
        acc.wr_en   = mem_wr;
        acc.wr_addr = ctrl.mem_addr;
        acc.wr_data = {bist_pkg::systolic_size{bg_word}};  // same word on every lane
        acc.rd_addr = ctrl.mem_addr - 1'b1;  // read trails write by one address
    end

endmodule

`default_nettype wire

// ==== source/response_checker.sv ====
// result stage of the BIST controller
// expected register, lane compare, memory fail level and fault map
`timescale 1ns/1ps
`default_nettype none

module response_checker (
    input  logic                                clk,
    input  logic                                rst_n,
    input  bist_pkg::bist_ctrl_t                ctrl,
    input  logic [bist_pkg::psum_width-1:0]     envm_answer,
    input  bist_pkg::psum_row_t                 acc_wr_data,
    input  bist_pkg::psum_row_t                 psum_in,   // acc read data or scan-out row
    output logic                                mismatch,
    output logic [bist_pkg::systolic_size-1:0]  fault_map
);

    bist_pkg::psum_row_t                expected_q;
    logic [bist_pkg::systolic_size-1:0] lane_err;
    logic                               mem_cmp;
    logic                               logic_cmp;

    // latch what the next compare should see
    always_ff @(posedge clk) begin
        case (ctrl.phase)
            bist_pkg::mem_write,
            bist_pkg::mem_write_read: expected_q <= acc_wr_data;
            bist_pkg::capture:        expected_q <= {bist_pkg::systolic_size{envm_answer}};
            default: ;
        endcase
    end

    always_comb begin
        for (int i = 0; i < bist_pkg::systolic_size; i++) begin
            lane_err[i] = (psum_in[i] != expected_q[i]);
        end
    end

    assign mem_cmp   = ctrl.compare_en &&
                       ((ctrl.phase == bist_pkg::mem_write_read) ||
                        (ctrl.phase == bist_pkg::mem_read));
    assign logic_cmp = ctrl.compare_en &&
                       ((ctrl.phase == bist_pkg::scan_in) ||
                        (ctrl.phase == bist_pkg::scan_out));

    // memory result reaches the sequencer one cycle after the read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mismatch <= 1'b0;
        end else begin
            mismatch <= mem_cmp && (|lane_err);
        end
    end

    // sticky per-column fault record
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_map <= '0;
        end else if (ctrl.run_start) begin
            fault_map <= '0;
        end else if (logic_cmp) begin
            fault_map <= fault_map | lane_err;
        end
    end

endmodule

`default_nettype wire

// ==== source/hybrid_bist.sv ====
// top level of the systolic array BIST controller
// decode, execute and result stages
`timescale 1ns/1ps
`default_nettype none

module hybrid_bist (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start,
    input  logic                                    test_mode,
    input  logic                                    bist_mode,    // 0 memory, 1 logic
    input  bist_pkg::envm_word_t                    envm,
    input  bist_pkg::psum_row_t                     psum_in,
    output logic [bist_pkg::pattern_idx_width-1:0]  pattern_idx,  // eNVM read index
    output logic                                    scan_en,
    output bist_pkg::test_vec_t                     test_vec,
    output bist_pkg::acc_port_t                     acc,
    output logic                                    test_done,
    output logic                                    mbist_fail,
    output logic [bist_pkg::systolic_size-1:0]      fault_map
);

    bist_pkg::bist_ctrl_t ctrl;
    logic                 mismatch;

    assign pattern_idx = ctrl.pattern_idx;

    bist_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .test_mode  (test_mode),
        .bist_mode  (bist_mode),
        .mismatch   (mismatch),
        .ctrl       (ctrl),
        .scan_en    (scan_en),
        .test_done  (test_done),
        .mbist_fail (mbist_fail)
    );

    pattern_driver u_driver (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .envm     (envm),
        .test_vec (test_vec),
        .acc      (acc)
    );

    response_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .envm_answer (envm.answer),
        .acc_wr_data (acc.wr_data),
        .psum_in     (psum_in),
        .mismatch    (mismatch),
        .fault_map   (fault_map)
    );

endmodule

`default_nettype wire

// ==== verification/tb_hybrid_bist.sv ====
// testbench for the systolic array BIST controller
// accumulator, eNVM and array models, test table and checks
`timescale 1ns/1ps
`default_nettype none

module tb_hybrid_bist;

    localparam int lanes    = bist_pkg::systolic_size;
    localparam int pw       = bist_pkg::psum_width;
    localparam int ww       = bist_pkg::weight_width;
    localparam int aw       = bist_pkg::activation_width;
    localparam int depth    = 1 << bist_pkg::addr_width;
    localparam int n_tests  = 6;
    localparam int max_wait = 500;  // cycles per wait
    localparam int shift_cycles   = 8;  // per pattern and for the final scan-out
    localparam int scan_in_cycles = bist_pkg::sa_pattern_depth * shift_cycles;

    typedef struct packed {
        logic             mode;        // 0 memory, 1 logic
        logic             fault_on;
        logic [2:0]       fault_lane;
        logic [lanes-1:0] col_mask;    // inverted array columns
        logic             exp_fail;
        logic [lanes-1:0] exp_map;
    } test_row_t;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   start;
    logic                                   test_mode;
    logic                                   bist_mode;
    bist_pkg::envm_word_t                   envm;
    bist_pkg::psum_row_t                    psum_in;
    logic [bist_pkg::pattern_idx_width-1:0] pattern_idx;
    logic                                   scan_en;
    bist_pkg::test_vec_t                    test_vec;
    bist_pkg::acc_port_t                    acc;
    logic                                   test_done;
    logic                                   mbist_fail;
    logic [lanes-1:0]                       fault_map;

    test_row_t                              tests [n_tests];
    test_row_t                              cur;
    bist_pkg::envm_word_t                   envm_tab [bist_pkg::sa_pattern_depth];
    bist_pkg::psum_row_t                    acc_mem [depth];
    logic [pw-1:0]                          resp_answer;  // last captured answer
    logic [pw-1:0]                          bg_exp;
    logic [bist_pkg::pattern_idx_width-1:0] prev_idx;
    int                                     wr_count [depth][depth];
    logic [15:0]                            idx_seen;
    int                                     shifts_seen;
    int                                     errors;
    int                                     failed_tests;
    int                                     tests_run;
    int                                     waited;
    int                                     err_before;
    logic                                   timed_out;
    integer                                 seed;

    hybrid_bist DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .test_mode   (test_mode),
        .bist_mode   (bist_mode),
        .envm        (envm),
        .psum_in     (psum_in),
        .pattern_idx (pattern_idx),
        .scan_en     (scan_en),
        .test_vec    (test_vec),
        .acc         (acc),
        .test_done   (test_done),
        .mbist_fail  (mbist_fail),
        .fault_map   (fault_map)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // march background k built bit by bit from its description
    function automatic logic [pw-1:0] background(input int k);
        logic [pw-1:0] w;
        for (int i = 0; i < pw; i++) begin
            case (k)
                0: w[i] = 1'b0;
                1: w[i] = 1'b1;
                2: w[i] = ((pw - 1 - i) % 2 == 0);  // 1010 from msb
                3: w[i] = ((pw - 1 - i) % 2 == 1);
                4: w[i] = (i < (pw + 1) / 2);
                5: w[i] = (i >= (pw + 1) / 2);
                6: w[i] = (i % 5 == 0);             // walking one
                default: w[i] = (i % 5 != 0);       // walking zero
            endcase
        end
        return w;
    endfunction

    // eNVM answers in the same cycle
    assign envm = (pattern_idx < bist_pkg::sa_pattern_depth) ? envm_tab[pattern_idx] : '0;

    always @(posedge clk) begin
        if (acc.wr_en) begin
            acc_mem[acc.wr_addr] <= acc.wr_data;
        end
        if (!scan_en) begin
            resp_answer <= envm.answer;  // array response after capture
        end
    end

    // accumulator read or array scan-out row
    always_comb begin
        if (bist_mode) begin
            for (int i = 0; i < lanes; i++) begin
                psum_in[i] = cur.col_mask[i] ? ~resp_answer : resp_answer;
            end
        end else begin
            psum_in = acc_mem[acc.rd_addr];
            if (cur.fault_on) begin
                psum_in[cur.fault_lane][0] = 1'b1;  // stuck at one
            end
        end
    end

    // bus monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (acc.wr_en) begin
                bg_exp = background(int'(pattern_idx));
                if (pattern_idx >= depth || acc.wr_data !== {lanes{bg_exp}}) begin
                    $display("mismatch at %0t: write addr %0d background %0d data %h",
                             $time, acc.wr_addr, pattern_idx, acc.wr_data);
                    errors++;
                end else begin
                    wr_count[pattern_idx][acc.wr_addr]++;
                end
            end
            if (scan_en) begin
                if (shifts_seen < scan_in_cycles) begin
                    if (test_vec.weight !== {lanes{envm_tab[pattern_idx].weight}} ||
                        test_vec.activation !== {lanes{envm_tab[pattern_idx].activation}}) begin
                        $display("mismatch at %0t: operand lanes differ from eNVM entry %0d",
                                 $time, pattern_idx);
                        errors++;
                    end
                    if (test_vec.psum !== {lanes{envm_tab[prev_idx].partial_sum}}) begin
                        $display("mismatch at %0t: psum lanes differ from eNVM entry %0d",
                                 $time, prev_idx);
                        errors++;
                    end
                end else if (test_vec !== '0) begin
                    // final scan-out shifts no new pattern in
                    $display("mismatch at %0t: test_vec lanes not zero in final scan-out",
                             $time);
                    errors++;
                end
                shifts_seen++;
                idx_seen[pattern_idx] = 1'b1;
            end
            prev_idx = pattern_idx;
        end
    end

    initial begin
        seed         = 83;
        errors       = 0;
        failed_tests = 0;
        tests_run    = 0;
        timed_out    = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        test_mode    = 1'b0;
        bist_mode    = 1'b0;
        cur          = '0;
        prev_idx     = '0;
        shifts_seen  = 0;
        for (int i = 0; i < bist_pkg::sa_pattern_depth; i++) begin
            envm_tab[i].weight      = ww'($random(seed));
            envm_tab[i].activation  = aw'($random(seed));
            envm_tab[i].partial_sum = pw'($random(seed));
            envm_tab[i].answer      = pw'($random(seed));
        end
        for (int a = 0; a < depth; a++) begin
            acc_mem[a] = {lanes{pw'(a * 1171 + 19'h1357)}};
        end
        // mode, fault_on, fault_lane, col_mask, exp_fail, exp_map
        tests[0] = {1'b0, 1'b0, 3'd0, 8'h00, 1'b0, 8'h00};
        tests[1] = {1'b0, 1'b1, 3'd3, 8'h00, 1'b1, 8'h00};
        tests[2] = {1'b1, 1'b0, 3'd0, 8'h00, 1'b0, 8'h00};
        tests[3] = {1'b1, 1'b0, 3'd0, 8'h24, 1'b0, 8'h24};  // columns 2 and 5
        tests[4] = {1'b1, 1'b0, 3'd0, 8'h00, 1'b0, 8'h00};
        tests[5] = {1'b0, 1'b0, 3'd0, 8'h00, 1'b0, 8'h00};

        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1;
        if (scan_en !== 1'b0 || acc.wr_en !== 1'b0 || test_done !== 1'b0 ||
            mbist_fail !== 1'b0 || fault_map !== '0) begin
            $display("mismatch at %0t: outputs not quiet after reset", $time);
            errors++;
        end

        for (int t = 0; t < n_tests && !timed_out; t++) begin
            cur         = tests[t];
            err_before  = errors;
            idx_seen    = '0;
            shifts_seen = 0;
            for (int b = 0; b < depth; b++) begin
                for (int a = 0; a < depth; a++) begin
                    wr_count[b][a] = 0;
                end
            end
            start     = 1'b1;
            test_mode = 1'b1;
            bist_mode = cur.mode;
            waited    = 0;
            while (!test_done && waited < max_wait) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!test_done) begin
                $display("timeout: test %0d never raised test_done", t);
                errors++;
                timed_out = 1'b1;
            end else begin
                if (mbist_fail !== cur.exp_fail) begin
                    $display("mismatch at %0t: mbist_fail %b, expected %b",
                             $time, mbist_fail, cur.exp_fail);
                    errors++;
                end
                if (fault_map !== cur.exp_map) begin
                    $display("mismatch at %0t: fault_map %h, expected %h",
                             $time, fault_map, cur.exp_map);
                    errors++;
                end
                if (!cur.mode && !cur.exp_fail) begin
                    for (int b = 0; b < depth; b++) begin
                        for (int a = 0; a < depth; a++) begin
                            if (wr_count[b][a] != 1) begin
                                $display("mismatch at %0t: background %0d addr %0d writes %0d",
                                         $time, b, a, wr_count[b][a]);
                                errors++;
                            end
                        end
                    end
                end
                if (cur.mode && idx_seen[bist_pkg::sa_pattern_depth-1:0] !== 12'hfff) begin
                    $display("mismatch at %0t: pattern indices seen %h", $time, idx_seen);
                    errors++;
                end
                if (cur.mode && shifts_seen != scan_in_cycles + shift_cycles) begin
                    $display("mismatch at %0t: %0d shift cycles, expected %0d",
                             $time, shifts_seen, scan_in_cycles + shift_cycles);
                    errors++;
                end
                start  = 1'b0;
                waited = 0;
                while (test_done && waited < max_wait) begin
                    @(posedge clk);
                    #1;
                    waited++;
                end
                if (test_done) begin
                    $display("timeout: test_done stayed high after start fell in test %0d", t);
                    errors++;
                    timed_out = 1'b1;
                end
            end
            tests_run++;
            if (errors != err_before) begin
                failed_tests++;
            end
            $display("test %0d %s run: %s", t, cur.mode ? "logic" : "memory",
                     (errors == err_before) ? "ok" : "failed");
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/bist_pkg.sv
source/bist_sequencer.sv
source/pattern_driver.sv
source/response_checker.sv
source/hybrid_bist.sv
verification/tb_hybrid_bist.sv

// ==== Bender.yml ====
package:
  name: hybrid_bist

sources:
  - source/bist_pkg.sv
  - source/bist_sequencer.sv
  - source/pattern_driver.sv
  - source/response_checker.sv
  - source/hybrid_bist.sv
  - target: test
    files:
      - verification/tb_hybrid_bist.sv
